/* rv_core.f */
+incdir+test
verilog/rv_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/load_store_unit.sv
verilog/rv_core.sv
test/rv_core_asserts.sv
test/rv_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = rv_core.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+100
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST))) test/rv_ref_model.svh
PASS_MSG  = Verification passed

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam int          DATA_WORDS = 64;
localparam logic [31:0] DATA_BASE  = 32'h0000_0400;    // 64-word data window

typedef struct packed {
    logic [31:0]                 pc;
    logic [31:0][31:0]           regs;
    logic [DATA_WORDS-1:0][31:0] mem;
} arch_state_t;

typedef struct packed {
    arch_state_t state;
    logic        load;
    logic        store;
    logic [31:0] addr;
    logic [31:0] data;
} step_result_t;

function automatic logic [5:0] data_index(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - DATA_BASE;
    return offset[7:2];
endfunction

// Initial data word scrambled from the full byte address
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic arch_state_t initial_state();
    arch_state_t st;
    logic [31:0] a;
    st = '0;
    for (int i = 0; i < DATA_WORDS; i++) begin
        a = DATA_BASE + i * 4;
        st.mem[data_index(a)] = fill_word(a);
    end
    return st;
endfunction

// Integer ops by funct3 where alt selects SUB or SRA
function automatic logic [31:0] int_op_result(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'd0, $signed(a) < $signed(b)};
        3'b011:  return {31'd0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end else begin
                return a >> b[4:0];
            end
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// One architectural step of the RV32I subset
function automatic step_result_t ref_step(input arch_state_t s, input logic [31:0] insn);
    step_result_t r;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  imm_i;
    logic [31:0]  imm_s;
    logic [31:0]  imm_b;
    logic [31:0]  imm_j;
    logic [31:0]  value;
    logic [4:0]   rd;
    logic [2:0]   f3;
    logic         wr;
    logic         take;
    rd    = insn[11:7];
    f3    = insn[14:12];
    a     = s.regs[insn[19:15]];
    b     = s.regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    r          = '0;
    r.state    = s;
    r.state.pc = s.pc + 32'd4;
    wr         = 1'b0;
    value      = '0;
    take       = 1'b0;
    case (insn[6:0])
        7'b0110111: begin   // LUI
            wr    = 1'b1;
            value = {insn[31:12], 12'd0};
        end
        7'b0010111: begin   // AUIPC
            wr    = 1'b1;
            value = s.pc + {insn[31:12], 12'd0};
        end
        7'b1101111: begin   // JAL
            wr         = 1'b1;
            value      = s.pc + 32'd4;
            r.state.pc = s.pc + imm_j;
        end
        7'b1100111: begin   // JALR
            wr         = 1'b1;
            value      = s.pc + 32'd4;
            r.state.pc = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
            case (f3)
                3'b000:  take = (a == b);
                3'b001:  take = (a != b);
                3'b100:  take = $signed(a) < $signed(b);
                3'b101:  take = $signed(a) >= $signed(b);
                3'b110:  take = a < b;
                3'b111:  take = a >= b;
                default: take = 1'b0;
            endcase
            if (take) begin
                r.state.pc = s.pc + imm_b;
            end
        end
        7'b0000011: begin
            if (f3 == 3'b010) begin
                r.load = 1'b1;
                r.addr = a + imm_i;
                wr     = 1'b1;
                value  = s.mem[data_index(r.addr)];
            end
        end
        7'b0100011: begin
            if (f3 == 3'b010) begin
                r.store = 1'b1;
                r.addr  = a + imm_s;
                r.data  = b;
                r.state.mem[data_index(r.addr)] = b;
            end
        end
        7'b0010011: begin
            wr    = 1'b1;
            value = int_op_result(f3, insn[30] && (f3 == 3'b101), a, imm_i);
        end
        7'b0110011: begin
            wr    = 1'b1;
            value = int_op_result(f3, insn[30], a, b);
        end
        default: ;          // Anything else only advances the PC
    endcase
    if (wr && rd != 5'd0) begin
        r.state.regs[rd] = value;
    end
    return r;
endfunction

`endif

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam int          PROG_WORDS    = 256;
    localparam int          BODY_WORDS    = 223;    // Random part before the register dump
    localparam int          RESET_CYCLES  = 8;
    localparam int          CLK_PERIOD_NS = 4;
    localparam int          TIMEOUT_NS    = (RESET_CYCLES + PROG_WORDS * 2 + 64) * CLK_PERIOD_NS;
    localparam logic [31:0] LAST_PC       = (PROG_WORDS - 1) * 4;

    `include "rv_ref_model.svh"

    logic        clk;
    logic        reset         = 1'b1;
    logic [31:0] instruction;
    logic [31:0] bus_read_data = '0;
    logic [31:0] rom_pc;
    logic [31:0] bus_address;
    logic [31:0] bus_wr_data;
    logic        bus_wr_enable;
    logic        bus_rd_enable;

    logic [31:0] rom [PROG_WORDS];
    logic [31:0] dmem [DATA_WORDS];

    arch_state_t  model;
    arch_state_t  pending;      // State after the load in flight
    step_result_t step;
    logic         load_wait = 1'b0;
    logic         done      = 1'b0;
    int           spin      = 0;
    int           checks    = 0;
    int           errors    = 0;

    rv_core dut_i (
        .i_clk           (clk),
        .i_reset         (reset),
        .i_instruction   (instruction),
        .i_bus_read_data (bus_read_data),
        .o_rom_pc        (rom_pc),
        .o_bus_address   (bus_address),
        .o_bus_wr_data   (bus_wr_data),
        .o_bus_wr_enable (bus_wr_enable),
        .o_bus_rd_enable (bus_rd_enable)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    assign instruction = rom[rom_pc[9:2]];  // Combinational ROM

    // Data memory with read data one cycle after the strobe
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                dmem[i] <= fill_word(DATA_BASE + i * 4);
            end
        end else begin
            if (bus_wr_enable) begin
                dmem[data_index(bus_address)] <= bus_wr_data;
            end
            if (bus_rd_enable) begin
                bus_read_data <= dmem[data_index(bus_address)];
            end
        end
    end

    function automatic logic [4:0] random_reg();
        logic [31:0] r;
        r = $urandom_range(0, 15);
        return r[4:0];
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] off;
        logic [31:0] addr;
        logic [31:0] w;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        int          kind;
        int          k;
        for (int i = 0; i < BODY_WORDS; i++) begin
            r    = $urandom();
            rd   = random_reg();
            rs1  = random_reg();
            rs2  = random_reg();
            f3   = r[14:12];
            kind = (i == 0) ? 0 : int'($urandom_range(0, 9));
            k    = int'($urandom_range(1, 8));
            if (i + k > BODY_WORDS) begin
                k = BODY_WORDS - i;     // Forward and never past the dump
            end
            off  = k * 4;
            w    = $urandom_range(0, 63);
            addr = DATA_BASE + (w << 2);
            case (kind)
                0: rom[i] = {r[31:12], rd, 7'b0110111};
                1: rom[i] = {r[31:12], rd, 7'b0010111};
                2, 3: begin
                    imm = r[31:20];
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm = {1'b0, r[30] & f3[2], 5'd0, r[24:20]};
                    end
                    rom[i] = {imm, rs1, f3, rd, 7'b0010011};
                end
                4, 5: rom[i] = {1'b0, r[30] & (f3 == 3'b000 || f3 == 3'b101), 5'd0,
                                rs2, rs1, f3, rd, 7'b0110011};
                6: begin
                    w  = $urandom_range(0, 5);
                    f3 = w[2:0] + ((w[2:0] > 3'd1) ? 3'd2 : 3'd0);
                    if (r[0]) begin
                        rs2 = rs1;      // Equal operands now and then
                    end
                    rom[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
                end
                7: begin
                    if (r[1]) begin
                        rom[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
                    end else begin
                        w      = (i + k) * 4;
                        w[0]   = r[2];  // Odd target whose bit 0 must drop
                        rom[i] = {w[11:0], 5'd0, 3'b000, rd, 7'b1100111};
                    end
                end
                8: rom[i] = {addr[11:0], 5'd0, 3'b010, rd, 7'b0000011};
                default: rom[i] = {addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], 7'b0100011};
            endcase
        end
        // Dump x0..x31 to the data window and then spin
        for (int i = BODY_WORDS; i < PROG_WORDS - 1; i++) begin
            w      = i - BODY_WORDS;
            addr   = DATA_BASE + (w << 2);
            rom[i] = {addr[11:5], w[4:0], 5'd0, 3'b010, addr[4:0], 7'b0100011};
        end
        rom[PROG_WORDS-1] = {25'd0, 7'b1101111};
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Comparator sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            model     = initial_state();
            load_wait = 1'b0;
            spin      = 0;
            check_value("reset_pc", 32'd0, rom_pc);
            check_value("reset_rd_strobe", 32'd0, {31'd0, bus_rd_enable});
            check_value("reset_wr_strobe", 32'd0, {31'd0, bus_wr_enable});
        end else if (!done) begin
            check_value("fetch_pc", model.pc, rom_pc);
            if (load_wait) begin
                check_value("load_wait_rd_strobe", 32'd0, {31'd0, bus_rd_enable});
                check_value("load_wait_wr_strobe", 32'd0, {31'd0, bus_wr_enable});
                model     = pending;
                load_wait = 1'b0;
            end else begin
                step = ref_step(model, rom[model.pc[9:2]]);
                check_value("rd_strobe", {31'd0, step.load}, {31'd0, bus_rd_enable});
                check_value("wr_strobe", {31'd0, step.store}, {31'd0, bus_wr_enable});
                if (step.load || step.store) begin
                    check_value("bus_address", step.addr, bus_address);
                end
                if (step.store) begin
                    check_value("store_data", step.data, bus_wr_data);
                end
                if (model.pc == LAST_PC) begin
                    spin++;
                end
                if (step.load) begin
                    pending   = step.state;
                    load_wait = 1'b1;
                end else begin
                    model = step.state;
                end
                if (spin >= 3) begin
                    done = 1'b1;
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the core did not reach the final self-jump within %0d ns", TIMEOUT_NS);
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.asserts_i.failures);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hb61174bd));
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        wait (done);
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.asserts_i.failures);
        if (errors == 0 && dut_i.asserts_i.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* test/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts (
    input logic        i_clk,
    input logic        i_reset,
    input logic        i_rd_enable,
    input logic        i_wr_enable,
    input logic [31:0] i_pc
);

    int failures = 0;

    // One bus direction per cycle
    strobes_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_rd_enable && i_wr_enable))
        else begin
            $error("Read and write strobes high in the same cycle");
            failures++;
        end

    load_gap: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rd_enable |=> !i_rd_enable)       // Wait cycle carries no new request
        else begin
            $error("Read strobe high in the load wait cycle");
            failures++;
        end

    pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pc[1:0] == 2'b00)
        else begin
            $error("Fetch address not word aligned");
            failures++;
        end

endmodule

bind rv_core rv_core_asserts asserts_i (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_rd_enable (o_bus_rd_enable),
    .i_wr_enable (o_bus_wr_enable),
    .i_pc        (o_rom_pc)
);

/* verilog/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic [XLEN-1:0] i_instruction,
    input  logic [XLEN-1:0] i_bus_read_data,
    output logic [XLEN-1:0] o_rom_pc,
    output logic [XLEN-1:0] o_bus_address,
    output logic [XLEN-1:0] o_bus_wr_data,
    output logic            o_bus_wr_enable,
    output logic            o_bus_rd_enable
);

    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data, rs2_data;
    logic [XLEN-1:0] alu_a, alu_b;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic [XLEN-1:0] pc, link;
    logic            pc_hold;
    logic            rd_write;
    logic [XLEN-1:0] rd_data;

    decoder decoder_i (
        .i_instruction (i_instruction),
        .o_ctrl        (ctrl),
        .o_imm         (imm)
    );

    reg_file reg_file_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1      (ctrl.rs1),
        .i_rs2      (ctrl.rs2),
        .i_rd       (ctrl.rd),
        .i_write    (rd_write),
        .i_wdata    (rd_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    // Operand muxes, PC for AUIPC and immediate for I and S forms
    assign alu_a = ctrl.alu_a_pc  ? pc  : rs1_data;
    assign alu_b = ctrl.alu_b_imm ? imm : rs2_data;

    alu alu_i (
        .i_op           (ctrl.alu_op),
        .i_a            (alu_a),
        .i_b            (alu_b),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    pc_unit pc_unit_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_hold         (pc_hold),
        .i_ctrl         (ctrl),
        .i_imm          (imm),
        .i_alu_result   (alu_result),
        .i_branch_taken (branch_taken),
        .o_pc           (pc),
        .o_link         (link)
    );

    load_store_unit load_store_unit_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_ctrl          (ctrl),
        .i_alu_result    (alu_result),
        .i_store_data    (rs2_data),
        .i_link          (link),
        .i_imm           (imm),
        .i_bus_read_data (i_bus_read_data),
        .o_bus_address   (o_bus_address),
        .o_bus_wr_data   (o_bus_wr_data),
        .o_bus_wr_enable (o_bus_wr_enable),
        .o_bus_rd_enable (o_bus_rd_enable),
        .o_pc_hold       (pc_hold),
        .o_rd_write      (rd_write),
        .o_rd_data       (rd_data)
    );

    assign o_rom_pc = pc;   // Fetch address straight from the PC register

endmodule

/* verilog/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_reset,
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_alu_result,
    input  logic [XLEN-1:0] i_store_data,
    input  logic [XLEN-1:0] i_link,
    input  logic [XLEN-1:0] i_imm,
    input  logic [XLEN-1:0] i_bus_read_data,
    output logic [XLEN-1:0] o_bus_address,
    output logic [XLEN-1:0] o_bus_wr_data,
    output logic            o_bus_wr_enable,
    output logic            o_bus_rd_enable,
    output logic            o_pc_hold,
    output logic            o_rd_write,
    output logic [XLEN-1:0] o_rd_data
);

    seq_state_e state, state_next;
    logic       load_issue;

    // First cycle of a load, request goes out and the PC waits
    assign load_issue = i_ctrl.mem_read && (state == SEQ_EXEC);

    always_comb begin
        case (state)
            SEQ_EXEC:      state_next = load_issue ? SEQ_LOAD_WAIT : SEQ_EXEC;
            default:       state_next = SEQ_EXEC;   // Data arrives, load retires
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state <= SEQ_EXEC;
        end else begin
            state <= state_next;
        end
    end

    assign o_bus_address   = i_alu_result;      // rs1 + imm
    assign o_bus_wr_data   = i_store_data;
    assign o_bus_wr_enable = i_ctrl.mem_write;
    assign o_bus_rd_enable = load_issue;
    assign o_pc_hold       = load_issue;

    // No write back until the memory word is on the bus
    assign o_rd_write = i_ctrl.reg_write && !load_issue;

    always_comb begin
        case (i_ctrl.wb_src)
            WB_LINK: o_rd_data = i_link;
            WB_MEM:  o_rd_data = i_bus_read_data;
            WB_IMM:  o_rd_data = i_imm;
            default: o_rd_data = i_alu_result;
        endcase
    end

endmodule

/* verilog/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_hold,
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_imm,
    input  logic [XLEN-1:0] i_alu_result,
    input  logic            i_branch_taken,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_link
);

    pc_src_e         pc_src;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus_four;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jalr_target;
    logic [XLEN-1:0] pc_next;

    // Source select from the jump and branch decision
    always_comb begin
        if (i_ctrl.is_jal || (i_ctrl.is_branch && i_branch_taken)) begin
            pc_src = PC_BRANCH;
        end else if (i_ctrl.is_jalr) begin
            pc_src = PC_JALR;
        end else begin
            pc_src = PC_PLUS_FOUR;
        end
    end

    assign pc_plus_four  = pc + 32'd4;
    assign branch_target = pc + i_imm;                  // B and J offsets alike
    assign jalr_target   = {i_alu_result[XLEN-1:1], 1'b0};

    always_comb begin
        case (pc_src)
            PC_BRANCH: pc_next = branch_target;
            PC_JALR:   pc_next = jalr_target;
            default:   pc_next = pc_plus_four;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            pc <= '0;
        end else if (!i_hold) begin
            pc <= pc_next;
        end
    end

    assign o_pc   = pc;
    assign o_link = pc_plus_four;   // Return address for JAL and JALR

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic [XLEN-1:0] o_result,
    output logic            o_branch_taken
);

    logic [XLEN-1:0] sum;
    logic [4:0]      shamt;
    logic            lt_signed, lt_unsigned;

    assign sum         = i_a + i_b;
    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        o_result = sum;     // Branch ops keep a + b
        case (i_op)
            SUB:     o_result = i_a - i_b;
            SLL:     o_result = i_a << shamt;
            SLT:     o_result = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU:    o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            XOR:     o_result = i_a ^ i_b;
            SRL:     o_result = i_a >> shamt;
            SRA:     o_result = $unsigned($signed(i_a) >>> shamt);
            OR:      o_result = i_a | i_b;
            AND:     o_result = i_a & i_b;
            default: ;
        endcase
    end

    always_comb begin
        case (i_op)
            BEQ:     o_branch_taken = (i_a == i_b);
            BNE:     o_branch_taken = (i_a != i_b);
            BLT:     o_branch_taken = lt_signed;
            BGE:     o_branch_taken = !lt_signed;
            BLTU:    o_branch_taken = lt_unsigned;
            BGEU:    o_branch_taken = !lt_unsigned;
            default: o_branch_taken = 1'b0;
        endcase
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic                  i_write,
    input  logic [XLEN-1:0]       i_wdata,
    output logic [XLEN-1:0]       o_rs1_data,
    output logic [XLEN-1:0]       o_rs2_data
);

    logic [XLEN-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Reads see the value before this cycle's write
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
    input  logic [XLEN-1:0] i_instruction,
    output ctrl_t           o_ctrl,
    output logic [XLEN-1:0] o_imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    alu_op_e    arith_op;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode   = opcode_e'(i_instruction[6:0]);
    assign funct3   = i_instruction[14:12];
    assign funct7_5 = i_instruction[30];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
    assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
    assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
                    i_instruction[30:25], i_instruction[11:8], 1'b0};
    assign imm_u = {i_instruction[31:12], 12'b0};
    assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
                    i_instruction[20], i_instruction[30:21], 1'b0};

    // funct3 to ALU operation, SUB only exists for register-register
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP_REG && funct7_5) ? SUB : ADD;
            3'b001:  arith_op = SLL;
            3'b010:  arith_op = SLT;
            3'b011:  arith_op = SLTU;
            3'b100:  arith_op = XOR;
            3'b101:  arith_op = funct7_5 ? SRA : SRL;
            3'b110:  arith_op = OR;
            default: arith_op = AND;
        endcase
    end

    always_comb begin
        o_ctrl        = '0;     // Unknown opcodes fall through as no-ops
        o_ctrl.rd     = i_instruction[11:7];
        o_ctrl.rs1    = i_instruction[19:15];
        o_ctrl.rs2    = i_instruction[24:20];
        o_ctrl.alu_op = ADD;
        o_ctrl.wb_src = WB_ALU;
        o_imm         = imm_i;
        case (opcode)
            OP_LUI: begin
                o_imm            = imm_u;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_src    = WB_IMM;
            end
            OP_AUIPC: begin
                o_imm            = imm_u;
                o_ctrl.alu_a_pc  = 1'b1;
                o_ctrl.alu_b_imm = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_JAL: begin
                o_imm            = imm_j;
                o_ctrl.is_jal    = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_src    = WB_LINK;
            end
            OP_JALR: begin
                o_ctrl.is_jalr   = 1'b1;
                o_ctrl.alu_b_imm = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_src    = WB_LINK;
            end
            OP_BRANCH: begin
                o_imm            = imm_b;
                o_ctrl.is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
                case (funct3)
                    3'b000:  o_ctrl.alu_op = BEQ;
                    3'b001:  o_ctrl.alu_op = BNE;
                    3'b100:  o_ctrl.alu_op = BLT;
                    3'b101:  o_ctrl.alu_op = BGE;
                    3'b110:  o_ctrl.alu_op = BLTU;
                    default: o_ctrl.alu_op = BGEU;
                endcase
            end
            OP_LOAD: begin
                o_ctrl.alu_b_imm = 1'b1;
                o_ctrl.mem_read  = (funct3 == 3'b010);     // LW only
                o_ctrl.reg_write = (funct3 == 3'b010);
                o_ctrl.wb_src    = WB_MEM;
            end
            OP_STORE: begin
                o_imm            = imm_s;
                o_ctrl.alu_b_imm = 1'b1;
                o_ctrl.mem_write = (funct3 == 3'b010);     // SW only
            end
            OP_IMM: begin
                o_ctrl.alu_op    = arith_op;
                o_ctrl.alu_b_imm = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_REG: begin
                o_ctrl.alu_op    = arith_op;
                o_ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        BEQ, BNE, BLT, BGE, BLTU, BGEU       // Branch compares
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_PLUS_FOUR,
        PC_BRANCH,      // PC + imm, JAL and taken branches
        PC_JALR         // rs1 + imm, bit 0 cleared
    } pc_src_e;

    typedef enum logic {
        SEQ_EXEC,
        SEQ_LOAD_WAIT
    } seq_state_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK,
        WB_MEM,
        WB_IMM
    } wb_src_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        alu_op_e               alu_op;
        logic                  alu_b_imm;   // Operand b is the immediate
        logic                  alu_a_pc;    // Operand a is the PC
        logic                  reg_write;
        wb_src_e               wb_src;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  mem_read;
        logic                  mem_write;
    } ctrl_t;

endpackage
